//--- sources.f
+incdir+include
rtl/fpm_pkg.sv
rtl/stage_pipe.sv
rtl/fp_operand_unpack.sv
rtl/fp_mul_lane.sv
rtl/fp_result_pack.sv
rtl/fp_vec_mul.sv
test/fp_vec_mul_sva.sv
test/fp_vec_mul_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, the log decides pass or fail
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module fp_vec_mul_tb \
	-f sources.f -o fp_vec_mul_sim &&
	./obj_dir/fp_vec_mul_sim | tee sim.log
grep -q "TEST PASSED" sim.log 2>/dev/null && echo "simulation ok" ||
	{ echo "simulation failed"; exit 1; }

//--- test/fp_vec_mul_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpm_consts.svh"

module fp_vec_mul_tb;

	localparam int TAG_W = `FPM_TAG_W;
	localparam int VEC_W = `FPM_LANES * `FPM_WORD_W;

	logic             clk;
	logic             rst;
	logic             in_valid;
	logic             flag_clear;
	logic             out_valid;
	logic             flag_invalid;
	logic             flag_overflow;
	logic             flag_underflow;
	logic [TAG_W-1:0] in_tag;
	logic [TAG_W-1:0] out_tag;
	logic [VEC_W-1:0] in_a;
	logic [VEC_W-1:0] in_b;
	logic [VEC_W-1:0] out_data;

	logic [TAG_W-1:0] tag_q [$];   // expected results with the oldest first
	logic [VEC_W-1:0] data_q [$];
	integer           seed;
	logic             ended;

	fp_vec_mul fp_vec_mul_i (.*);

	bind fp_vec_mul fp_vec_mul_sva sva_i (.*);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	task automatic fail_run(input string line);
		$display("%s", line);
		ended = 1'b1;
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	function automatic string mismatch(input string name, input logic [VEC_W-1:0] exp,
		input logic [VEC_W-1:0] got);
		return $sformatf("Fail at %0t: %s expected %h observed %h", $time, name, exp, got);
	endfunction

	// lane i takes word i mod 4 with word 0 in the low bits
	function automatic logic [VEC_W-1:0] spread(input logic [127:0] w);
		logic [VEC_W-1:0] v;
		for (int i = 0; i < `FPM_LANES; i++)
			v[i*32 +: 32] = w[(i % 4)*32 +: 32];
		return v;
	endfunction

	// exact for magnitudes below 2**24
	function automatic logic [31:0] encode_int(input logic sign, input logic [31:0] mag);
		int          msb;
		logic [31:0] shifted;
		msb = -1;
		for (int i = 0; i < 24; i++) begin
			if (mag[i])
				msb = i;   // highest one wins
		end
		if (msb < 0)
			return {sign, 31'd0};
		shifted = mag << (23 - msb);
		return {sign, 8'(127 + msb), shifted[22:0]};
	endfunction

	task automatic send_vector(input logic [TAG_W-1:0] tag, input logic [VEC_W-1:0] a,
		input logic [VEC_W-1:0] b, input logic [VEC_W-1:0] p);
		@(posedge clk);
		tag_q.push_back(tag);
		data_q.push_back(p);
		in_valid <= 1'b1;
		in_tag   <= tag;
		in_a     <= a;
		in_b     <= b;
	endtask

	task automatic stop_input();
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	task automatic drain_results(input int n);
		int               waited;
		int               seen;
		logic [TAG_W-1:0] exp_tag;
		logic [VEC_W-1:0] exp_data;
		waited = 0;
		seen   = 0;
		while (seen < n) begin
			assert (waited < n + 4 * `FPM_LATENCY)
				else fail_run("timed out waiting for out_valid");
			@(negedge clk);
			waited++;
			if (out_valid) begin
				assert (tag_q.size() > 0) else fail_run("out_valid with no vector in flight");
				exp_tag  = tag_q.pop_front();
				exp_data = data_q.pop_front();
				seen++;
				assert (out_tag === exp_tag)
					else fail_run(mismatch("out_tag", VEC_W'(exp_tag), VEC_W'(out_tag)));
				assert (out_data === exp_data)
					else fail_run(mismatch("out_data", exp_data, out_data));
			end
		end
	endtask

	task automatic check_flags(input logic [2:0] exp);   // invalid, overflow, underflow
		assert ({flag_invalid, flag_overflow, flag_underflow} === exp)
			else fail_run(mismatch("flag_invalid/overflow/underflow", VEC_W'(exp),
				VEC_W'({flag_invalid, flag_overflow, flag_underflow})));
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			assert (!out_valid) else fail_run("out_valid rose with no vector in flight");
		end
	endtask

	task automatic clear_flags();
		@(posedge clk);
		flag_clear <= 1'b1;
		@(posedge clk);
		flag_clear <= 1'b0;
		@(negedge clk);
		check_flags(3'b000);
	endtask

	task automatic directed_vector(input logic [TAG_W-1:0] tag, input logic [127:0] a,
		input logic [127:0] b, input logic [127:0] p, input logic [2:0] flags);
		send_vector(tag, spread(a), spread(b), spread(p));
		stop_input();
		drain_results(1);
		check_flags(flags);
	endtask

	task automatic reset_state();
		@(negedge clk);
		check_flags(3'b000);
		idle_cycles(6);
	endtask

	// 1.5 x 2.5 = 3.75 under three sign pairs and 2 x -0.5 in lane 3
	task automatic exact_products();
		directed_vector(8'h11,
			{32'h40000000, 32'hBFC00000, 32'hBFC00000, 32'h3FC00000},
			{32'hBF000000, 32'hC0200000, 32'h40200000, 32'h40200000},
			{32'hBF800000, 32'h40700000, 32'hC0700000, 32'h40700000}, 3'b000);
	endtask

	// -0 x 3, inf x -2, nan x 1, 0 x -inf
	task automatic special_operands();
		directed_vector(8'h22,
			{32'h00000000, 32'h7FC00000, 32'h7F800000, 32'h80000000},
			{32'hFF800000, 32'h3F800000, 32'hC0000000, 32'h40400000},
			{32'hFFFFFFFF, 32'h7FFFFFFF, 32'hFF800000, 32'h80000000}, 3'b100);
		clear_flags();
	endtask

	// 2**100 squared overflows and 2**-100 squared underflows
	task automatic range_limits();
		directed_vector(8'h33,
			{32'h8D800000, 32'h0D800000, 32'hF1800000, 32'h71800000},
			{32'h0D800000, 32'h0D800000, 32'h71800000, 32'h71800000},
			{32'h80000000, 32'h00000000, 32'hFF800000, 32'h7F800000}, 3'b011);
		idle_cycles(3);
		check_flags(3'b011);
		clear_flags();
	endtask

	// subnormals scaled back into the normal range by powers of two
	task automatic subnormal_inputs();
		directed_vector(8'h44,
			{32'h80000003, 32'h00300000, 32'h00400000, 32'h00000001},
			{32'h7F000000, 32'hDF800000, 32'h44800000, 32'h7F000000},
			{32'hB5400000, 32'h9FC00000, 32'h05000000, 32'h34800000}, 3'b000);
	endtask

	// back to back vectors of 12 bit integers whose products are exact
	task automatic random_stream(input int count);
		logic [VEC_W-1:0] a;
		logic [VEC_W-1:0] b;
		logic [VEC_W-1:0] p;
		logic [31:0]      ra;
		logic [31:0]      rb;
		fork
			begin
				for (int k = 0; k < count; k++) begin
					for (int l = 0; l < `FPM_LANES; l++) begin
						ra = $random(seed);
						rb = $random(seed);
						a[l*32 +: 32] = encode_int(ra[31], {20'd0, ra[11:0]});
						b[l*32 +: 32] = encode_int(rb[31], {20'd0, rb[11:0]});
						p[l*32 +: 32] = encode_int(ra[31] ^ rb[31],
							{20'd0, ra[11:0]} * {20'd0, rb[11:0]});
					end
					send_vector(TAG_W'(8'h40 + k), a, b, p);
				end
				stop_input();
			end
			drain_results(count);
		join
		check_flags(3'b000);
	endtask

	initial begin
		$timeformat(-9, 0, " ns", 0);
		seed       = 32'ha4733b1e;
		ended      = 1'b0;
		rst        = 1'b1;
		in_valid   = 1'b0;
		in_tag     = '0;
		in_a       = '0;
		in_b       = '0;
		flag_clear = 1'b0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		reset_state();
		exact_products();
		special_operands();
		range_limits();
		subnormal_inputs();
		random_stream(12);
		idle_cycles(4);
		ended = 1'b1;
		$display("TEST PASSED");
		$finish;
	end

	final begin
		if (!ended)
			$display("TEST FAILED");
	end

endmodule

`default_nettype wire

//--- test/fp_vec_mul_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpm_consts.svh"

module fp_vec_mul_sva (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic flag_clear,
	input logic out_valid,
	input logic flag_invalid,
	input logic flag_overflow,
	input logic flag_underflow
);

	localparam int LAT = `FPM_LATENCY;

	// every accepted vector leaves exactly LAT cycles later, nothing else does
	a_latency: assert property (@(posedge clk) disable iff (rst)
		out_valid == $past(in_valid, LAT))
		else $error("out_valid does not follow in_valid by %0d cycles", LAT);

	a_reset_low: assert property (@(posedge clk)
		rst |=> !(out_valid || flag_invalid || flag_overflow || flag_underflow))
		else $error("outputs not low in the cycle after reset");

	// sticky flags only drop on a clear
	a_hold_invalid: assert property (@(posedge clk) disable iff (rst)
		$fell(flag_invalid) |-> $past(flag_clear))
		else $error("flag_invalid fell without flag_clear");
	a_hold_overflow: assert property (@(posedge clk) disable iff (rst)
		$fell(flag_overflow) |-> $past(flag_clear))
		else $error("flag_overflow fell without flag_clear");
	a_hold_underflow: assert property (@(posedge clk) disable iff (rst)
		$fell(flag_underflow) |-> $past(flag_clear))
		else $error("flag_underflow fell without flag_clear");

endmodule

`default_nettype wire

//--- rtl/fp_vec_mul.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpm_consts.svh"

module fp_vec_mul (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               in_valid,
	input  logic [`FPM_TAG_W-1:0]              in_tag,
	input  logic [`FPM_LANES*`FPM_WORD_W-1:0]  in_a,
	input  logic [`FPM_LANES*`FPM_WORD_W-1:0]  in_b,
	input  logic                               flag_clear,
	output logic                               out_valid,
	output logic [`FPM_TAG_W-1:0]              out_tag,
	output logic [`FPM_LANES*`FPM_WORD_W-1:0]  out_data,
	output logic                               flag_invalid,
	output logic                               flag_overflow,
	output logic                               flag_underflow
);

	localparam int WORD_W = `FPM_WORD_W;

	logic                                op_valid;
	fpm_pkg::fp_unpacked_t               op_a [`FPM_LANES];
	fpm_pkg::fp_unpacked_t               op_b [`FPM_LANES];

	logic [`FPM_LANES-1:0]               lane_valid;
	logic [`FPM_LANES*WORD_W-1:0]        lane_data;
	logic [`FPM_LANES-1:0]               lane_invalid;
	logic [`FPM_LANES-1:0]               lane_overflow;
	logic [`FPM_LANES-1:0]               lane_underflow;

	fp_operand_unpack unpack_i (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.in_a     (in_a),
		.in_b     (in_b),
		.op_valid (op_valid),
		.op_a     (op_a),
		.op_b     (op_b)
	);

	for (genvar g = 0; g < `FPM_LANES; g++) begin : g_lane
		fp_mul_lane lane_i (
			.clk           (clk),
			.rst           (rst),
			.op_valid      (op_valid),
			.op_a          (op_a[g]),
			.op_b          (op_b[g]),
			.res_valid     (lane_valid[g]),
			.res_data      (lane_data[g*WORD_W +: WORD_W]),
			.res_invalid   (lane_invalid[g]),
			.res_overflow  (lane_overflow[g]),
			.res_underflow (lane_underflow[g])
		);
	end

	// tag bypasses the datapath, same depth as the whole pipeline
	stage_pipe #(
		.payload_t (logic [`FPM_TAG_W-1:0]),
		.DEPTH     (`FPM_LATENCY)
	) tag_pipe_i (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_data   (in_tag),
		.out_valid (),
		.out_data  (out_tag)
	);

	fp_result_pack pack_i (
		.clk            (clk),
		.rst            (rst),
		.flag_clear     (flag_clear),
		.res_valid      (lane_valid),
		.res_data       (lane_data),
		.res_invalid    (lane_invalid),
		.res_overflow   (lane_overflow),
		.res_underflow  (lane_underflow),
		.out_valid      (out_valid),
		.out_data       (out_data),
		.flag_invalid   (flag_invalid),
		.flag_overflow  (flag_overflow),
		.flag_underflow (flag_underflow)
	);

endmodule

`default_nettype wire

//--- rtl/fp_result_pack.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpm_consts.svh"

module fp_result_pack (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               flag_clear,
	input  logic [`FPM_LANES-1:0]              res_valid,
	input  logic [`FPM_LANES*`FPM_WORD_W-1:0]  res_data,
	input  logic [`FPM_LANES-1:0]              res_invalid,
	input  logic [`FPM_LANES-1:0]              res_overflow,
	input  logic [`FPM_LANES-1:0]              res_underflow,
	output logic                               out_valid,
	output logic [`FPM_LANES*`FPM_WORD_W-1:0]  out_data,
	output logic                               flag_invalid,
	output logic                               flag_overflow,
	output logic                               flag_underflow
);

	logic raise_invalid;
	logic raise_overflow;
	logic raise_underflow;

	// only lanes holding a result may raise a flag
	assign raise_invalid   = |(res_valid & res_invalid);
	assign raise_overflow  = |(res_valid & res_overflow);
	assign raise_underflow = |(res_valid & res_underflow);

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid      <= 1'b0;
			flag_invalid   <= 1'b0;
			flag_overflow  <= 1'b0;
			flag_underflow <= 1'b0;
		end else begin
			out_valid      <= |res_valid;   // lanes run in lockstep
			// a new event beats a clear in the same cycle
			flag_invalid   <= (flag_invalid & ~flag_clear) | raise_invalid;
			flag_overflow  <= (flag_overflow & ~flag_clear) | raise_overflow;
			flag_underflow <= (flag_underflow & ~flag_clear) | raise_underflow;
		end
	end

	always_ff @(posedge clk) begin
		out_data <= res_data;
	end

endmodule

`default_nettype wire

//--- rtl/fp_mul_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpm_consts.svh"

module fp_mul_lane (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     op_valid,
	input  fpm_pkg::fp_unpacked_t    op_a,
	input  fpm_pkg::fp_unpacked_t    op_b,
	output logic                     res_valid,
	output logic [`FPM_WORD_W-1:0]   res_data,
	output logic                     res_invalid,
	output logic                     res_overflow,
	output logic                     res_underflow
);

	localparam int EXP_W   = `FPM_EXP_W;
	localparam int MAN_W   = `FPM_MAN_W;
	localparam int BIAS    = `FPM_BIAS;
	localparam int EXP_MAX = (1 << EXP_W) - 1;   // all ones, reserved for inf and nan

	fpm_pkg::fp_class_pair_t pair_in;
	fpm_pkg::fp_class_pair_t pair_q;
	logic                    s1_valid;

	logic [2*MAN_W+1:0]      prod_q;
	logic signed [9:0]       exp_sum_q;

	logic signed [10:0]      exp_biased;
	logic [MAN_W-1:0]        man_norm;
	logic                    any_nan;
	logic                    any_zero;
	logic                    any_inf;
	logic [`FPM_WORD_W-1:0]  word_next;
	logic                    inv_next;
	logic                    ovf_next;
	logic                    unf_next;

	assign pair_in.sign  = op_a.sign ^ op_b.sign;
	assign pair_in.cls_a = op_a.cls;
	assign pair_in.cls_b = op_b.cls;

	// stage 1, classes and sign ride next to the product
	stage_pipe #(
		.payload_t (fpm_pkg::fp_class_pair_t),
		.DEPTH     (1)
	) class_pipe_i (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (op_valid),
		.in_data   (pair_in),
		.out_valid (s1_valid),
		.out_data  (pair_q)
	);

	always_ff @(posedge clk) begin
		prod_q    <= op_a.man * op_b.man;   // 24 x 24 -> 48
		exp_sum_q <= op_a.exp + op_b.exp;
	end

	// stage 2 normalize
	always_comb begin
		if (prod_q[2*MAN_W+1]) begin   // product in [2,4)
			man_norm   = prod_q[2*MAN_W -: MAN_W];
			exp_biased = exp_sum_q + 11'sd1 + 11'(BIAS);
		end else begin
			man_norm   = prod_q[2*MAN_W-1 -: MAN_W];
			exp_biased = exp_sum_q + 11'(BIAS);
		end
	end

	assign any_nan  = (pair_q.cls_a == fpm_pkg::FPC_NAN) || (pair_q.cls_b == fpm_pkg::FPC_NAN);
	assign any_zero = (pair_q.cls_a == fpm_pkg::FPC_ZERO) || (pair_q.cls_b == fpm_pkg::FPC_ZERO);
	assign any_inf  = (pair_q.cls_a == fpm_pkg::FPC_INF) || (pair_q.cls_b == fpm_pkg::FPC_INF);

	// special cases first, then range limits
	always_comb begin
		inv_next = 1'b0;
		ovf_next = 1'b0;
		unf_next = 1'b0;
		if (any_nan || (any_zero && any_inf)) begin
			word_next = {pair_q.sign, {EXP_W{1'b1}}, {MAN_W{1'b1}}};   // canonical nan
			inv_next  = 1'b1;
		end else if (any_inf) begin
			word_next = {pair_q.sign, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
		end else if (any_zero) begin
			word_next = {pair_q.sign, {EXP_W{1'b0}}, {MAN_W{1'b0}}};
		end else if (exp_biased >= 11'(EXP_MAX)) begin
			word_next = {pair_q.sign, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
			ovf_next  = 1'b1;
		end else if (exp_biased < 11'sd1) begin
			// no subnormal outputs, flush to zero
			word_next = {pair_q.sign, {EXP_W{1'b0}}, {MAN_W{1'b0}}};
			unf_next  = 1'b1;
		end else begin
			word_next = {pair_q.sign, exp_biased[EXP_W-1:0], man_norm};   // truncated
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			res_valid <= 1'b0;
		else
			res_valid <= s1_valid;
	end

	always_ff @(posedge clk) begin
		res_data      <= word_next;
		res_invalid   <= inv_next;
		res_overflow  <= ovf_next;
		res_underflow <= unf_next;
	end

endmodule

`default_nettype wire

//--- rtl/fp_operand_unpack.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpm_consts.svh"

module fp_operand_unpack (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                in_valid,
	input  logic [`FPM_LANES*`FPM_WORD_W-1:0]   in_a,
	input  logic [`FPM_LANES*`FPM_WORD_W-1:0]   in_b,
	output logic                                op_valid,
	output fpm_pkg::fp_unpacked_t               op_a [`FPM_LANES],
	output fpm_pkg::fp_unpacked_t               op_b [`FPM_LANES]
);

	localparam int EXP_W  = `FPM_EXP_W;
	localparam int MAN_W  = `FPM_MAN_W;
	localparam int WORD_W = `FPM_WORD_W;
	localparam int BIAS   = `FPM_BIAS;

	// leading zeros of a 24 bit mantissa, highest set bit wins
	function automatic logic [4:0] lead_zeros(input logic [MAN_W:0] m);
		logic [4:0] n;
		n = 5'(MAN_W + 1);
		for (int i = 0; i <= MAN_W; i++) begin
			if (m[i])
				n = 5'(MAN_W - i);
		end
		return n;
	endfunction

	function automatic fpm_pkg::fp_unpacked_t unpack_word(input logic [WORD_W-1:0] w);
		fpm_pkg::fp_unpacked_t u;
		logic [EXP_W-1:0] e;
		logic [MAN_W-1:0] m;
		logic [4:0]       lz;
		e  = w[WORD_W-2 -: EXP_W];
		m  = w[MAN_W-1:0];
		lz = lead_zeros({1'b0, m});
		u.sign = w[WORD_W-1];
		u.exp  = $signed({2'b00, e}) - 10'(BIAS);
		u.man  = {1'b1, m};
		if (e == '1) begin
			u.cls = (m == '0) ? fpm_pkg::FPC_INF : fpm_pkg::FPC_NAN;
		end else if (e != '0) begin
			u.cls = fpm_pkg::FPC_NORMAL;
		end else if (m == '0) begin
			u.cls = fpm_pkg::FPC_ZERO;
		end else begin
			// subnormal: move the leading one up to the hidden bit
			u.cls = fpm_pkg::FPC_NORMAL;
			u.man = {1'b0, m} << lz;
			u.exp = 10'(1 - BIAS) - $signed({5'b00000, lz});
		end
		return u;
	endfunction

	always_ff @(posedge clk) begin
		if (rst)
			op_valid <= 1'b0;
		else
			op_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `FPM_LANES; i++) begin
			op_a[i] <= unpack_word(in_a[i*WORD_W +: WORD_W]);
			op_b[i] <= unpack_word(in_b[i*WORD_W +: WORD_W]);
		end
	end

endmodule

`default_nettype wire

//--- rtl/stage_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module stage_pipe #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 1
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	logic     valid_q [DEPTH];
	payload_t data_q  [DEPTH];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				valid_q[i] <= 1'b0;
			end
		end else begin
			valid_q[0] <= in_valid;
			for (int i = 1; i < DEPTH; i++) begin
				valid_q[i] <= valid_q[i-1];
			end
		end
	end

	// data just follows along
	always_ff @(posedge clk) begin
		data_q[0] <= in_data;
		for (int i = 1; i < DEPTH; i++) begin
			data_q[i] <= data_q[i-1];
		end
	end

	assign out_valid = valid_q[DEPTH-1];
	assign out_data  = data_q[DEPTH-1];

endmodule

`default_nettype wire

//--- rtl/fpm_pkg.sv
`default_nettype none

`include "fpm_consts.svh"

package fpm_pkg;

	// operand class after unpacking
	// subnormals are normalized and show up as FPC_NORMAL
	typedef enum logic [1:0] {
		FPC_ZERO,
		FPC_NORMAL,
		FPC_INF,
		FPC_NAN
	} fp_class_t;

	// operand as seen by a lane
	typedef struct packed {
		logic                    sign;
		logic signed [9:0]       exp;   // unbiased
		logic [`FPM_MAN_W:0]     man;   // explicit leading one
		fp_class_t               cls;
	} fp_unpacked_t;

	// what a lane carries next to its product from stage 1 to stage 2
	typedef struct packed {
		logic      sign;   // product sign
		fp_class_t cls_a;
		fp_class_t cls_b;
	} fp_class_pair_t;

endpackage

`default_nettype wire

//--- include/fpm_consts.svh
`ifndef FPM_CONSTS_SVH
`define FPM_CONSTS_SVH

// vector shape
`define FPM_LANES   4
`define FPM_TAG_W   8

// single precision field widths
`define FPM_EXP_W   8
`define FPM_MAN_W   23
`define FPM_WORD_W  (1 + `FPM_EXP_W + `FPM_MAN_W)

`define FPM_BIAS    127      // exponent bias

// input strobe to output pulse, in cycles
// unpack 1 + lane 2 + pack 1
`define FPM_LATENCY 4

`endif
